// ==== design/ex_alu.sv ====
`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_alu (
  input  ex_pkg::id_ex_t ex_in,
  output ex_pkg::xlen_t  alu_result
);

  ex_pkg::xlen_t             alu_a;
  ex_pkg::xlen_t             alu_b;
  ex_pkg::alu_op_e           alu_op;
  logic [`EX_SHAMT_W-1:0]    shamt;

  // Operand A select, unused encoding falls back to rs1
  always_comb begin
    case (ex_in.alu_a_src)
      ex_pkg::ALU_A_ZERO: alu_a = '0;
      ex_pkg::ALU_A_PC:   alu_a = ex_in.pc;
      default:            alu_a = ex_in.rs1_data;
    endcase
  end

  // Operand B is the immediate for I-type, loads, stores and jumps
  assign alu_b = ex_in.alu_b_src ? ex_in.imm : ex_in.rs2_data;

  // Only the low bits of B count for shifts
  assign shamt = alu_b[`EX_SHAMT_W-1:0];

  // Operation decode
  always_comb begin
    alu_op = ex_pkg::ALU_OP_ADD;
    case (ex_in.alu_instr)
      ex_pkg::ALU_INSTR_ADD: alu_op = ex_pkg::ALU_OP_ADD;
      ex_pkg::ALU_INSTR_SUB: alu_op = ex_pkg::ALU_OP_SUB;
      default: begin
        case (ex_in.funct3)
          // SUB exists only as R-type, ADDI ignores funct7
          3'b000: alu_op = (ex_in.funct7_b5 && ex_in.op_b5) ? ex_pkg::ALU_OP_SUB :
                                                              ex_pkg::ALU_OP_ADD;
          3'b001: alu_op = ex_pkg::ALU_OP_SLL;
          3'b010: alu_op = ex_pkg::ALU_OP_SLT;
          3'b011: alu_op = ex_pkg::ALU_OP_SLTU;
          3'b100: alu_op = ex_pkg::ALU_OP_XOR;
          // SRAI keeps funct7 bit 5 in the immediate, so no opcode check here
          3'b101: alu_op = ex_pkg::ALU_OP_SRA;
          3'b110: alu_op = ex_pkg::ALU_OP_OR;
          default: alu_op = ex_pkg::ALU_OP_AND;
        endcase
        if (ex_in.funct3 == 3'b101 && !ex_in.funct7_b5) begin
          alu_op = ex_pkg::ALU_OP_SRL;
        end
      end
    endcase
  end

  // Arithmetic and logic
  always_comb begin
    case (alu_op)
      ex_pkg::ALU_OP_SUB:  alu_result = alu_a - alu_b;
      ex_pkg::ALU_OP_SLL:  alu_result = alu_a << shamt;
      ex_pkg::ALU_OP_SLT:  alu_result = ex_pkg::xlen_t'($signed(alu_a) < $signed(alu_b));
      ex_pkg::ALU_OP_SLTU: alu_result = ex_pkg::xlen_t'(alu_a < alu_b);
      ex_pkg::ALU_OP_XOR:  alu_result = alu_a ^ alu_b;
      ex_pkg::ALU_OP_SRL:  alu_result = alu_a >> shamt;
      ex_pkg::ALU_OP_SRA:  alu_result = ex_pkg::xlen_t'($signed(alu_a) >>> shamt);
      ex_pkg::ALU_OP_OR:   alu_result = alu_a | alu_b;
      ex_pkg::ALU_OP_AND:  alu_result = alu_a & alu_b;
      default:             alu_result = alu_a + alu_b;
    endcase
  end

endmodule

// ==== design/ex_branch.sv ====
`timescale 1ns/1ps

module ex_branch (
  input  ex_pkg::id_ex_t  ex_in,
  input  ex_pkg::xlen_t   alu_result,
  output logic            branch_taken,
  output ex_pkg::xlen_t   jb_target,
  output logic            misalign_trap,
  output ex_pkg::pc_sel_e pc_sel,
  output ex_pkg::xlen_t   pc_redirect_target
);

  logic          op_eq;
  logic          op_lt;
  logic          op_ltu;
  logic          cond;
  logic          jb_active;
  ex_pkg::xlen_t target_pc_rel;
  ex_pkg::xlen_t target_reg;

  // Shared comparators for the six conditions
  assign op_eq  = ex_in.rs1_data == ex_in.rs2_data;
  assign op_lt  = $signed(ex_in.rs1_data) < $signed(ex_in.rs2_data);
  assign op_ltu = ex_in.rs1_data < ex_in.rs2_data;

  always_comb begin
    case (ex_in.funct3)
      3'b000:  cond = op_eq;
      3'b001:  cond = !op_eq;
      3'b100:  cond = op_lt;
      3'b101:  cond = !op_lt;
      3'b110:  cond = op_ltu;
      3'b111:  cond = !op_ltu;
      // 010 and 011 are not branch encodings
      default: cond = 1'b0;
    endcase
  end

  // Taken only means something for a real branch
  assign branch_taken = ex_in.is_branch && cond;

  // JAL and branches use their own adder
  assign target_pc_rel = ex_in.pc + ex_in.imm;

  // JALR: ALU forms rs1 + imm, bit 0 cleared
  assign target_reg = {alu_result[$bits(ex_pkg::xlen_t)-1:1], 1'b0};

  assign jb_target = ex_in.jb_target_src ? target_reg : target_pc_rel;

  // Any control transfer that actually leaves the sequential path
  assign jb_active = branch_taken || ex_in.is_jal || ex_in.is_jalr;

  // Targets must be word aligned without the C extension
  assign misalign_trap = jb_active && (|jb_target[1:0]);

  // No prediction, so every taken transfer redirects from EX
  assign pc_sel = jb_active ? ex_pkg::PC_SEL_REDIRECT : ex_pkg::PC_SEL_SEQUENTIAL;

  assign pc_redirect_target = jb_target;

endmodule

// ==== design/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width of the integer core
`define EX_XLEN 32

// Shift amount width, low bits of operand B
`define EX_SHAMT_W 5

// Register index width
`define EX_REG_W 5

// Result source select width, decoded in WB
`define EX_RES_SRC_W 3

// Restoring divider produces one quotient bit per cycle
`define EX_DIV_STEPS `EX_XLEN

// Trap code width and values
`define EX_TRAP_W 2
`define EX_TRAP_NONE 2'd0
`define EX_TRAP_MISALIGN 2'd1

`endif

// ==== design/ex_divider.sv ====
`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_divider (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          is_mc,
  input  logic [2:0]    funct3,
  input  ex_pkg::xlen_t rs1,
  input  ex_pkg::xlen_t rs2,
  output logic          op_active,
  output logic          mc_in_progress,
  output ex_pkg::xlen_t result
);

  localparam int XLEN  = `EX_XLEN;
  localparam int CNT_W = $clog2(`EX_DIV_STEPS) + 1;

  typedef enum logic {
    MC_IDLE,
    MC_EXEC
  } mc_state_e;

  mc_state_e     state;
  mc_state_e     state_next;
  logic          start;
  logic          div_start;
  logic          busy;
  logic [CNT_W-1:0] count;

  // Operands held for the whole operation
  ex_pkg::xlen_t rs1_cap;
  ex_pkg::xlen_t rs2_cap;
  logic [2:0]    op_cap;

  // Divider datapath
  logic          in_signed;
  ex_pkg::xlen_t rs1_mag;
  ex_pkg::xlen_t rs2_mag;
  ex_pkg::xlen_t quo;
  ex_pkg::xlen_t rem;
  ex_pkg::xlen_t dvs;
  logic [XLEN:0] trial;
  logic [XLEN:0] diff;

  // Result fix-up
  logic          is_signed;
  logic          a_neg;
  logic          b_neg;
  logic          div_zero;
  logic          overflow;
  ex_pkg::xlen_t q_fix;
  ex_pkg::xlen_t r_fix;

  assign start          = (state == MC_IDLE) && is_mc;
  // DIV, DIVU, REM and REMU all have funct3 bit 2 set
  assign div_start      = start && funct3[2];
  assign mc_in_progress = (state == MC_EXEC);

  // FSM next state, op_active tells ID to hold its instruction
  always_comb begin
    state_next = state;
    op_active  = 1'b0;
    case (state)
      MC_IDLE: begin
        if (is_mc) begin
          op_active  = 1'b1;
          state_next = MC_EXEC;
        end
      end
      default: begin
        if (busy) begin
          op_active = 1'b1;
        end else begin
          state_next = MC_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= MC_IDLE;
      busy  <= 1'b0;
      count <= '0;
    end else begin
      state <= state_next;
      if (div_start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        // One quotient bit per cycle
        if (count == CNT_W'(`EX_DIV_STEPS - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Magnitudes of the live operands for the start cycle
  assign in_signed = !funct3[0];
  assign rs1_mag   = (in_signed && rs1[XLEN-1]) ? -rs1 : rs1;
  assign rs2_mag   = (in_signed && rs2[XLEN-1]) ? -rs2 : rs2;

  // Restoring step: shift in next dividend bit, try the subtract
  assign trial = {rem, quo[XLEN-1]};
  assign diff  = trial - {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (start) begin
      rs1_cap <= rs1;
      rs2_cap <= rs2;
      op_cap  <= funct3;
    end
    if (div_start) begin
      quo <= rs1_mag;
      rem <= '0;
      dvs <= rs2_mag;
    end else if (busy) begin
      // Borrow out means the trial did not fit
      quo <= {quo[XLEN-2:0], !diff[XLEN]};
      rem <= diff[XLEN] ? trial[XLEN-1:0] : diff[XLEN-1:0];
    end
  end

  assign is_signed = !op_cap[0];
  assign a_neg     = is_signed && rs1_cap[XLEN-1];
  assign b_neg     = is_signed && rs2_cap[XLEN-1];
  assign div_zero  = (rs2_cap == '0);
  // Most negative value over minus one
  assign overflow  = is_signed && (rs1_cap == {1'b1, {(XLEN-1){1'b0}}}) && (rs2_cap == '1);

  // Quotient negative on sign mismatch, remainder takes the dividend sign
  assign q_fix = (a_neg ^ b_neg) ? -quo : quo;
  assign r_fix = a_neg ? -rem : rem;

  // Funct3 bit 1 picks remainder over quotient
  always_comb begin
    if (op_cap[1]) begin
      if (div_zero) begin
        result = rs1_cap;
      end else if (overflow) begin
        result = '0;
      end else begin
        result = r_fix;
      end
    end else begin
      if (div_zero) begin
        result = '1;
      end else if (overflow) begin
        result = rs1_cap;
      end else begin
        result = q_fix;
      end
    end
  end

endmodule

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            m_ready,
  input  ex_pkg::ex_mem_t next,
  output ex_pkg::ex_mem_t q
);

  always_ff @(posedge clk) begin
    // Control fields, reset and flushed
    if (!rst_n) begin
      q.valid        <= 1'b0;
      q.reg_write    <= 1'b0;
      q.mem_read     <= 1'b0;
      q.mem_write    <= 1'b0;
      q.is_branch    <= 1'b0;
      q.is_jalr      <= 1'b0;
      q.is_jmp       <= 1'b0;
      q.branch_taken <= 1'b0;
      q.trap         <= 1'b0;
    end else if (m_ready) begin
      q.valid        <= flush ? 1'b0 : next.valid;
      q.reg_write    <= flush ? 1'b0 : next.reg_write;
      q.mem_read     <= flush ? 1'b0 : next.mem_read;
      q.mem_write    <= flush ? 1'b0 : next.mem_write;
      q.is_branch    <= flush ? 1'b0 : next.is_branch;
      q.is_jalr      <= flush ? 1'b0 : next.is_jalr;
      q.is_jmp       <= flush ? 1'b0 : next.is_jmp;
      q.branch_taken <= flush ? 1'b0 : next.branch_taken;
      q.trap         <= flush ? 1'b0 : next.trap;
    end else begin
      // MEM stalled: keep the instruction, but never repeat a memory access
      q.mem_read  <= 1'b0;
      q.mem_write <= 1'b0;
    end

    // Payload follows m_ready only, flush or not
    if (m_ready) begin
      q.trap_code  <= next.trap_code;
      q.res_src    <= next.res_src;
      q.rd         <= next.rd;
      q.funct3     <= next.funct3;
      q.alu_result <= next.alu_result;
      q.rs1_data   <= next.rs1_data;
      q.rs2_data   <= next.rs2_data;
      q.pc_plus4   <= next.pc_plus4;
      q.jb_target  <= next.jb_target;
      q.m_result   <= next.m_result;
    end
  end

endmodule

// ==== design/ex_pkg.sv ====
`include "ex_defines.svh"

package ex_pkg;

  // One data word
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // ALU class from the main decoder
  typedef enum logic [1:0] {
    ALU_INSTR_ADD    = 2'b00,
    ALU_INSTR_SUB    = 2'b01,
    ALU_INSTR_FUNCT3 = 2'b10
  } alu_instr_e;

  // Operation applied by the ALU
  typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'd0,
    ALU_OP_SUB  = 4'd1,
    ALU_OP_SLL  = 4'd2,
    ALU_OP_SLT  = 4'd3,
    ALU_OP_SLTU = 4'd4,
    ALU_OP_XOR  = 4'd5,
    ALU_OP_SRL  = 4'd6,
    ALU_OP_SRA  = 4'd7,
    ALU_OP_OR   = 4'd8,
    ALU_OP_AND  = 4'd9
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    ALU_A_RS1  = 2'b00,
    ALU_A_ZERO = 2'b01,
    ALU_A_PC   = 2'b10
  } alu_a_src_e;

  // Next PC source towards IF
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'b00,
    PC_SEL_REDIRECT   = 2'b01
  } pc_sel_e;

  // Instruction as handed over from ID
  typedef struct packed {
    logic                     valid;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    alu_a_src_e               alu_a_src;
    // Immediate when set
    logic                     alu_b_src;
    alu_instr_e               alu_instr;
    logic [`EX_RES_SRC_W-1:0] res_src;
    logic                     is_branch;
    logic                     is_jal;
    logic                     is_jalr;
    // Register-indirect target when set
    logic                     jb_target_src;
    logic                     is_mc;
    // Opcode bit 5 splits R-type from I-type
    logic                     op_b5;
    logic [2:0]               funct3;
    logic                     funct7_b5;
    logic [`EX_REG_W-1:0]     rd;
    xlen_t                    rs1_data;
    xlen_t                    rs2_data;
    xlen_t                    imm;
    xlen_t                    pc;
    xlen_t                    pc_plus4;
  } id_ex_t;

  // Result handed on to MEM
  typedef struct packed {
    logic                     valid;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    logic                     is_branch;
    logic                     is_jalr;
    // JAL or JALR
    logic                     is_jmp;
    logic                     branch_taken;
    logic                     trap;
    logic [`EX_TRAP_W-1:0]    trap_code;
    logic [`EX_RES_SRC_W-1:0] res_src;
    logic [`EX_REG_W-1:0]     rd;
    logic [2:0]               funct3;
    xlen_t                    alu_result;
    xlen_t                    rs1_data;
    xlen_t                    rs2_data;
    xlen_t                    pc_plus4;
    xlen_t                    jb_target;
    xlen_t                    m_result;
  } ex_mem_t;

endpackage

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::id_ex_t  ex_in,
  input  logic            ex_mem_flush,
  input  logic            m_ready,
  output ex_pkg::ex_mem_t mem_out,
  output logic            m_valid,
  output logic            op_active,
  output ex_pkg::pc_sel_e pc_sel,
  output ex_pkg::xlen_t   pc_redirect_target
);

  ex_pkg::xlen_t   alu_result;
  logic            branch_taken;
  ex_pkg::xlen_t   jb_target;
  logic            misalign_trap;
  ex_pkg::xlen_t   m_result;
  logic            mc_in_progress;
  ex_pkg::ex_mem_t ex_mem_next;

  ex_alu alu (
    .ex_in      (ex_in),
    .alu_result (alu_result)
  );

  ex_branch branch (
    .ex_in              (ex_in),
    .alu_result         (alu_result),
    .branch_taken       (branch_taken),
    .jb_target          (jb_target),
    .misalign_trap      (misalign_trap),
    .pc_sel             (pc_sel),
    .pc_redirect_target (pc_redirect_target)
  );

  // Divide and remainder, ID stalls on op_active
  ex_divider divider (
    .clk            (clk),
    .rst_n          (rst_n),
    .is_mc          (ex_in.is_mc),
    .funct3         (ex_in.funct3),
    .rs1            (ex_in.rs1_data),
    .rs2            (ex_in.rs2_data),
    .op_active      (op_active),
    .mc_in_progress (mc_in_progress),
    .result         (m_result)
  );

  // Next EX/MEM value
  always_comb begin
    ex_mem_next.valid        = ex_in.valid;
    ex_mem_next.reg_write    = ex_in.reg_write;
    ex_mem_next.mem_read     = ex_in.mem_read;
    ex_mem_next.mem_write    = ex_in.mem_write;
    ex_mem_next.is_branch    = ex_in.is_branch;
    ex_mem_next.is_jalr      = ex_in.is_jalr;
    ex_mem_next.is_jmp       = ex_in.is_jal || ex_in.is_jalr;
    ex_mem_next.branch_taken = branch_taken;
    // Misaligned target is the only trap raised in EX
    ex_mem_next.trap         = misalign_trap;
    ex_mem_next.trap_code    = misalign_trap ? `EX_TRAP_MISALIGN : `EX_TRAP_NONE;
    ex_mem_next.res_src      = ex_in.res_src;
    ex_mem_next.rd           = ex_in.rd;
    ex_mem_next.funct3       = ex_in.funct3;
    ex_mem_next.alu_result   = alu_result;
    ex_mem_next.rs1_data     = ex_in.rs1_data;
    ex_mem_next.rs2_data     = ex_in.rs2_data;
    ex_mem_next.pc_plus4     = ex_in.pc_plus4;
    ex_mem_next.jb_target    = jb_target;
    ex_mem_next.m_result     = m_result;
  end

  ex_mem_reg ex_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (ex_mem_flush),
    .m_ready (m_ready),
    .next    (ex_mem_next),
    .q       (mem_out)
  );

  // During the first divide cycle mem_out still holds the previous instruction
  // and passes; after that it holds partial divide results until EXEC ends
  assign m_valid = mem_out.valid && !mc_in_progress;

endmodule

// ==== files.f ====
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_divider.sv
design/ex_mem_reg.sv
design/ex_stage.sv
test/ex_checker.sv
test/ex_stage_tb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f files.f --top-module ex_stage_tb -Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0

// ==== test/ex_checker.sv ====
`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_checker (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::ex_mem_t mem_out,
  input  logic            m_valid,
  input  logic            op_active,
  input  ex_pkg::pc_sel_e pc_sel,
  input  ex_pkg::xlen_t   pc_redirect_target,
  input  logic            exp_push,
  input  ex_pkg::ex_mem_t exp_mem,
  input  logic            exp_m_valid,
  input  logic            exp_chk_mres,
  input  ex_pkg::pc_sel_e exp_pc_sel,
  input  ex_pkg::xlen_t   exp_pc_target,
  output int              check_count,
  output int              error_count
);

  // Register value expected one edge after the push
  typedef struct packed {
    ex_pkg::ex_mem_t mem;
    logic            m_valid;
    logic            chk_mres;
  } entry_t;

  entry_t pending[$];
  entry_t head;
  int     checks      = 0;
  int     errors      = 0;
  int     reset_edges = 0;
  int     active_run  = 0;

  assign check_count = checks;
  assign error_count = errors;

  function automatic logic [31:0] ctrl_bits(input ex_pkg::ex_mem_t m);
    return {23'd0, m.valid, m.reg_write, m.mem_read, m.mem_write, m.is_branch,
            m.is_jalr, m.is_jmp, m.branch_taken, m.trap};
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Flop outputs read here still hold the value loaded at the previous edge
  always @(posedge clk) begin
    if (!rst_n) begin
      // Synchronous reset shows from the second edge on
      if (reset_edges > 0) begin
        compare("control fields in reset", ctrl_bits(mem_out), 32'd0);
        compare("m_valid in reset", {31'd0, m_valid}, 32'd0);
        compare("op_active in reset", {31'd0, op_active}, 32'd0);
      end
      reset_edges++;
    end else begin
      if (pending.size() > 0) begin
        head = pending.pop_front();
        compare("control fields", ctrl_bits(mem_out), ctrl_bits(head.mem));
        compare("trap_code", {30'd0, mem_out.trap_code}, {30'd0, head.mem.trap_code});
        compare("res_src/rd/funct3", {21'd0, mem_out.res_src, mem_out.rd, mem_out.funct3},
                {21'd0, head.mem.res_src, head.mem.rd, head.mem.funct3});
        compare("alu_result", mem_out.alu_result, head.mem.alu_result);
        compare("rs1_data", mem_out.rs1_data, head.mem.rs1_data);
        compare("rs2_data", mem_out.rs2_data, head.mem.rs2_data);
        compare("pc_plus4", mem_out.pc_plus4, head.mem.pc_plus4);
        compare("jb_target", mem_out.jb_target, head.mem.jb_target);
        // Partial divider state is not meaningful
        if (head.chk_mres) begin
          compare("m_result", mem_out.m_result, head.mem.m_result);
        end
        compare("m_valid", {31'd0, m_valid}, {31'd0, head.m_valid});
      end
      if (exp_push) begin
        // Redirect is combinational on ex_in
        compare("pc_sel", {30'd0, pc_sel}, {30'd0, exp_pc_sel});
        compare("pc_redirect_target", pc_redirect_target, exp_pc_target);
        pending.push_back('{exp_mem, exp_m_valid, exp_chk_mres});
      end
      // Length of each op_active pulse
      if (op_active) begin
        active_run++;
      end else if (active_run > 0) begin
        compare("op_active cycle count", active_run, `EX_DIV_STEPS + 1);
        active_run = 0;
      end
    end
  end

endmodule

// ==== test/ex_stage_tb.sv ====
`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_stage_tb;

  localparam int N_ALU   = 40;
  localparam int N_JB    = 32;
  localparam int N_DIV   = 20;
  localparam int N_FLUSH = 4;
  localparam int N_STALL = 12;
  localparam int N_INSTR = N_ALU + N_JB + N_DIV + N_FLUSH + N_STALL;
  // A divide needs EX_DIV_STEPS+2 cycles, so 40 per instruction covers every kind
  localparam int MAX_CYCLES = 100 + 40 * N_INSTR;

  logic            clk;
  logic            rst_n;
  ex_pkg::id_ex_t  ex_in;
  logic            ex_mem_flush;
  logic            m_ready;
  ex_pkg::ex_mem_t mem_out;
  logic            m_valid;
  logic            op_active;
  ex_pkg::pc_sel_e pc_sel;
  ex_pkg::xlen_t   pc_redirect_target;

  // Expected values towards the checker
  logic            exp_push;
  ex_pkg::ex_mem_t exp_mem;
  logic            exp_m_valid;
  logic            exp_chk_mres;
  ex_pkg::pc_sel_e exp_pc_sel;
  ex_pkg::xlen_t   exp_pc_target;
  int              check_count;
  int              error_count;

  // What the EX/MEM register should hold after the next edge
  ex_pkg::ex_mem_t exp_reg;
  int              seed;
  int              cycles = 0;

  always #10 clk = ~clk;

  ex_stage dut0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_in              (ex_in),
    .ex_mem_flush       (ex_mem_flush),
    .m_ready            (m_ready),
    .mem_out            (mem_out),
    .m_valid            (m_valid),
    .op_active          (op_active),
    .pc_sel             (pc_sel),
    .pc_redirect_target (pc_redirect_target)
  );

  ex_checker chk0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .mem_out            (mem_out),
    .m_valid            (m_valid),
    .op_active          (op_active),
    .pc_sel             (pc_sel),
    .pc_redirect_target (pc_redirect_target),
    .exp_push           (exp_push),
    .exp_mem            (exp_mem),
    .exp_m_valid        (exp_m_valid),
    .exp_chk_mres       (exp_chk_mres),
    .exp_pc_sel         (exp_pc_sel),
    .exp_pc_target      (exp_pc_target),
    .check_count        (check_count),
    .error_count        (error_count)
  );

  // Reference model of RV32IM execute semantics
  function automatic void ex_model(input ex_pkg::id_ex_t in, output ex_pkg::ex_mem_t res,
                                   output ex_pkg::pc_sel_e psel, output ex_pkg::xlen_t tgt);
    ex_pkg::xlen_t a;
    ex_pkg::xlen_t b;
    ex_pkg::xlen_t alu;
    ex_pkg::xlen_t q;
    ex_pkg::xlen_t r;
    logic          taken;
    logic          jump;
    case (in.alu_a_src)
      ex_pkg::ALU_A_PC:   a = in.pc;
      ex_pkg::ALU_A_ZERO: a = '0;
      default:            a = in.rs1_data;
    endcase
    b = in.alu_b_src ? in.imm : in.rs2_data;
    case (in.alu_instr)
      ex_pkg::ALU_INSTR_ADD: alu = a + b;
      ex_pkg::ALU_INSTR_SUB: alu = a - b;
      default: begin
        case (in.funct3)
          // Only R-type has SUB
          3'd0: alu = (in.op_b5 && in.funct7_b5) ? a - b : a + b;
          3'd1: alu = a << b[4:0];
          3'd2: alu = {31'd0, $signed(a) < $signed(b)};
          3'd3: alu = {31'd0, a < b};
          3'd4: alu = a ^ b;
          3'd5: begin
            if (in.funct7_b5) begin
              alu = $signed(a) >>> b[4:0];
            end else begin
              alu = a >> b[4:0];
            end
          end
          3'd6: alu = a | b;
          default: alu = a & b;
        endcase
      end
    endcase
    case (in.funct3)
      3'd0: taken = in.rs1_data == in.rs2_data;
      3'd1: taken = in.rs1_data != in.rs2_data;
      3'd4: taken = $signed(in.rs1_data) < $signed(in.rs2_data);
      3'd5: taken = $signed(in.rs1_data) >= $signed(in.rs2_data);
      3'd6: taken = in.rs1_data < in.rs2_data;
      3'd7: taken = in.rs1_data >= in.rs2_data;
      default: taken = 1'b0;
    endcase
    taken = taken && in.is_branch;
    // JALR clears bit 0 of rs1 + imm
    tgt  = in.jb_target_src ? {alu[31:1], 1'b0} : in.pc + in.imm;
    jump = taken || in.is_jal || in.is_jalr;
    psel = jump ? ex_pkg::PC_SEL_REDIRECT : ex_pkg::PC_SEL_SEQUENTIAL;
    // Divide by zero and signed overflow follow the M extension
    if (in.rs2_data == '0) begin
      q = '1;
      r = in.rs1_data;
    end else if (!in.funct3[0] && in.rs1_data == 32'h8000_0000 && in.rs2_data == '1) begin
      q = in.rs1_data;
      r = '0;
    end else if (!in.funct3[0]) begin
      q = $signed(in.rs1_data) / $signed(in.rs2_data);
      r = $signed(in.rs1_data) % $signed(in.rs2_data);
    end else begin
      q = in.rs1_data / in.rs2_data;
      r = in.rs1_data % in.rs2_data;
    end
    res              = '0;
    res.valid        = in.valid;
    res.reg_write    = in.reg_write;
    res.mem_read     = in.mem_read;
    res.mem_write    = in.mem_write;
    res.is_branch    = in.is_branch;
    res.is_jalr      = in.is_jalr;
    res.is_jmp       = in.is_jal || in.is_jalr;
    res.branch_taken = taken;
    res.trap         = jump && (tgt[1:0] != 2'b00);
    res.trap_code    = res.trap ? `EX_TRAP_MISALIGN : `EX_TRAP_NONE;
    res.res_src      = in.res_src;
    res.rd           = in.rd;
    res.funct3       = in.funct3;
    res.alu_result   = alu;
    res.rs1_data     = in.rs1_data;
    res.rs2_data     = in.rs2_data;
    res.pc_plus4     = in.pc_plus4;
    res.jb_target    = tgt;
    res.m_result     = in.funct3[1] ? r : q;
  endfunction

  // Random operands, every control bit off
  function automatic ex_pkg::id_ex_t rand_base();
    ex_pkg::id_ex_t in;
    logic [31:0]    w;
    in          = '0;
    in.valid    = 1'b1;
    in.rs1_data = $random(seed);
    in.rs2_data = $random(seed);
    in.imm      = $random(seed);
    w           = $random(seed);
    in.pc       = {w[31:2], 2'b00};
    in.pc_plus4 = in.pc + 32'd4;
    w           = $random(seed);
    in.rd       = w[4:0];
    in.res_src  = w[10:8];
    return in;
  endfunction

  function automatic ex_pkg::id_ex_t rand_alu(input int k);
    ex_pkg::id_ex_t in;
    logic [31:0]    w;
    in           = rand_base();
    w            = $random(seed);
    in.reg_write = 1'b1;
    in.funct3    = w[2:0];
    in.funct7_b5 = w[3];
    in.alu_instr = ex_pkg::ALU_INSTR_FUNCT3;
    case (k % 4)
      // R-type
      0: in.op_b5 = 1'b1;
      // I-type
      1: in.alu_b_src = 1'b1;
      // Load or store address
      2: begin
        in.alu_instr = ex_pkg::ALU_INSTR_ADD;
        in.alu_b_src = 1'b1;
        in.mem_read  = w[4];
        in.mem_write = !w[4];
        in.reg_write = w[4];
      end
      // LUI or AUIPC
      default: begin
        in.alu_instr = ex_pkg::ALU_INSTR_ADD;
        in.alu_a_src = w[5] ? ex_pkg::ALU_A_PC : ex_pkg::ALU_A_ZERO;
        in.alu_b_src = 1'b1;
      end
    endcase
    return in;
  endfunction

  function automatic ex_pkg::id_ex_t rand_jump(input int k);
    ex_pkg::id_ex_t in;
    logic [31:0]    w;
    in = rand_base();
    w  = $random(seed);
    // About half of the targets land word aligned
    if (w[0]) begin
      in.imm      = {in.imm[31:2], 2'b00};
      in.rs1_data = {in.rs1_data[31:2], 2'b00};
    end
    case (k % 4)
      0, 1: begin
        in.is_branch = 1'b1;
        in.alu_instr = ex_pkg::ALU_INSTR_SUB;
        in.funct3    = w[3:1];
        // 010 and 011 fold onto BEQ and BNE
        if (in.funct3[2:1] == 2'b01) begin
          in.funct3[1] = 1'b0;
        end
        if (w[4]) begin
          in.rs2_data = in.rs1_data;
        end
      end
      2: begin
        in.is_jal    = 1'b1;
        in.reg_write = 1'b1;
      end
      default: begin
        in.is_jalr       = 1'b1;
        in.reg_write     = 1'b1;
        in.jb_target_src = 1'b1;
        in.alu_b_src     = 1'b1;
        in.alu_instr     = ex_pkg::ALU_INSTR_ADD;
      end
    endcase
    return in;
  endfunction

  // One cycle of stimulus, expected register value tracked alongside
  task automatic apply(input ex_pkg::id_ex_t in, input logic flush, input logic ready,
                       input logic mc_after, input logic chk_mres);
    ex_pkg::ex_mem_t nxt;
    ex_pkg::pc_sel_e psel;
    ex_pkg::xlen_t   tgt;
    ex_model(in, nxt, psel, tgt);
    if (ready) begin
      if (flush) begin
        nxt.valid        = 1'b0;
        nxt.reg_write    = 1'b0;
        nxt.mem_read     = 1'b0;
        nxt.mem_write    = 1'b0;
        nxt.is_branch    = 1'b0;
        nxt.is_jalr      = 1'b0;
        nxt.is_jmp       = 1'b0;
        nxt.branch_taken = 1'b0;
        nxt.trap         = 1'b0;
      end
      exp_reg = nxt;
    end else begin
      // Held, but memory strobes drop
      exp_reg.mem_read  = 1'b0;
      exp_reg.mem_write = 1'b0;
    end
    ex_in         = in;
    ex_mem_flush  = flush;
    m_ready       = ready;
    exp_push      = 1'b1;
    exp_mem       = exp_reg;
    exp_m_valid   = exp_reg.valid && !mc_after;
    exp_chk_mres  = chk_mres;
    exp_pc_sel    = psel;
    exp_pc_target = tgt;
    @(posedge clk);
    #2;
    exp_push = 1'b0;
  endtask

  // ID holds the divide while op_active is high
  task automatic run_divide(input ex_pkg::id_ex_t in);
    apply(in, 1'b0, 1'b1, 1'b1, 1'b0);
    while (op_active) begin
      apply(in, 1'b0, 1'b1, 1'b1, 1'b0);
    end
    // Quotient or remainder is final in the cycle after op_active falls
    apply(in, 1'b0, 1'b1, 1'b0, 1'b1);
  endtask

  task automatic run_divides();
    ex_pkg::id_ex_t in;
    ex_pkg::xlen_t  a;
    ex_pkg::xlen_t  b;
    for (int c = 0; c < N_DIV / 4; c++) begin
      for (int f = 4; f < 8; f++) begin
        in = rand_base();
        case (c)
          0: begin
            a = in.rs1_data;
            b = in.rs2_data;
          end
          1: begin
            a = 32'hffff_fc18;
            b = 32'd7;
          end
          2: begin
            a = 32'd1000;
            b = 32'hffff_fff9;
          end
          3: begin
            a = in.rs1_data;
            b = '0;
          end
          default: begin
            a = 32'h8000_0000;
            b = '1;
          end
        endcase
        in.rs1_data  = a;
        in.rs2_data  = b;
        in.is_mc     = 1'b1;
        in.reg_write = 1'b1;
        in.op_b5     = 1'b1;
        in.funct3    = f[2:0];
        run_divide(in);
      end
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed          = 32'h1e783ccd;
    clk           = 1'b0;
    rst_n         = 1'b0;
    ex_in         = '0;
    ex_mem_flush  = 1'b0;
    m_ready       = 1'b1;
    exp_push      = 1'b0;
    exp_mem       = '0;
    exp_m_valid   = 1'b0;
    exp_chk_mres  = 1'b0;
    exp_pc_sel    = ex_pkg::PC_SEL_SEQUENTIAL;
    exp_pc_target = '0;
    exp_reg       = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int k = 0; k < N_ALU; k++) begin
      apply(rand_alu(k), 1'b0, 1'b1, 1'b0, 1'b0);
    end
    for (int k = 0; k < N_JB; k++) begin
      apply(rand_jump(k), 1'b0, 1'b1, 1'b0, 1'b0);
    end
    run_divides();
    // Flush alternates ALU ops with branches and jumps
    for (int k = 0; k < N_FLUSH; k++) begin
      apply((k % 2 == 0) ? rand_alu(k) : rand_jump(k), 1'b1, 1'b1, 1'b0, 1'b0);
    end
    // Each memory access is followed by two stalled cycles
    for (int k = 0; k < N_STALL / 3; k++) begin
      apply(rand_alu(2), 1'b0, 1'b1, 1'b0, 1'b0);
      apply(rand_alu(k), 1'b0, 1'b0, 1'b0, 1'b0);
      apply(rand_jump(k), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    ex_in   = '0;
    m_ready = 1'b1;
    repeat (3) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
